/* design/uart_cmd_pkg.sv */
package uart_cmd_pkg;

  // Bit times in one frame: start, eight data, parity and stop.
  localparam int FRAME_BITS = 11;
  localparam int DATA_BITS  = 8;

  // Host command word. rw set means write.
  typedef struct packed {
    logic       rw;
    logic [6:0] addr;
    logic [7:0] data;
  } cmd_t;

  typedef enum logic [4:0] {
    IDLE           = 5'd0,
    RW_JUDGE       = 5'd1,
    W_ADDR_FRAME   = 5'd2,
    W_GAP          = 5'd3,
    W_DATA_FRAME   = 5'd4,
    R_ADDR_FRAME   = 5'd5,
    R_WAIT_START   = 5'd6,
    R_DATA_FRAME   = 5'd7,
    SEND_READ_DATA = 5'd8
  } state_e;

endpackage

/* design/uart_bit_timer.sv */
`timescale 1ns/10ps

module uart_bit_timer #(
  parameter int BR = 434
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       timer_start,
  input  logic       timer_half,
  output logic       bit_tick,
  output logic [3:0] bit_idx,
  output logic       frame_done
);

  localparam int CW = $clog2(BR);
  localparam logic [CW-1:0] LAST = CW'(BR - 1);
  localparam logic [CW-1:0] HALF = CW'(BR - BR / 2); // First tick lands half a bit later.

  logic [CW-1:0] cnt;
  logic          run;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run     <= 1'b0;
      cnt     <= '0;
      bit_idx <= '0;
    end else if (timer_start || timer_half) begin
      run     <= 1'b1;
      cnt     <= timer_half ? HALF : '0;
      bit_idx <= '0;
    end else if (run) begin
      if (bit_tick) begin
        cnt <= '0;
        if (frame_done) begin
          run     <= 1'b0; // Stops after the last bit until restarted.
          bit_idx <= '0;
        end else begin
          bit_idx <= bit_idx + 4'd1;
        end
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  assign bit_tick   = run && (cnt == LAST);
  assign frame_done = bit_tick && (bit_idx == 4'(uart_cmd_pkg::FRAME_BITS - 1));

endmodule

/* design/uart_tx_shift.sv */
`timescale 1ns/10ps

module uart_tx_shift (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_load,
  input  logic [7:0] tx_byte,
  input  logic       tx_shift,
  output logic       tx
);

  logic [uart_cmd_pkg::FRAME_BITS-1:0] frame_sh;
  logic                                parity;

  // Even parity makes the count of ones over data and parity even.
  assign parity = ^tx_byte;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_sh <= '1;
    end else if (tx_load) begin
      frame_sh <= {1'b1, parity, tx_byte, 1'b0};
    end else if (tx_shift) begin
      // Ones fill in from the top so the line returns to idle high.
      frame_sh <= {1'b1, frame_sh[uart_cmd_pkg::FRAME_BITS-1:1]};
    end
  end

  assign tx = frame_sh[0];

endmodule

/* design/uart_rx_shift.sv */
`timescale 1ns/10ps

module uart_rx_shift (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output logic       rx_start,
  input  logic       rx_sample,
  output logic [7:0] rx_byte,
  output logic       parity_ok
);

  logic rx_meta;
  logic rx_sync;
  logic rx_prev;

  // Data bits with the parity bit on top.
  logic [uart_cmd_pkg::DATA_BITS:0] rx_sh;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync; // Only for edge detection.
    end
  end

  assign rx_start = rx_prev && !rx_sync;

  // Bits arrive LSB first, so each new bit enters at the top.
  // The start bit falls off the bottom once the parity bit is in.
  always_ff @(posedge clk) begin
    if (rx_sample)
      rx_sh <= {rx_sync, rx_sh[uart_cmd_pkg::DATA_BITS:1]};
  end

  assign rx_byte   = rx_sh[uart_cmd_pkg::DATA_BITS-1:0];
  assign parity_ok = ~^rx_sh;

endmodule

/* design/uart_ctrl_fsm.sv */
`timescale 1ns/10ps

module uart_ctrl_fsm (
  input  logic               clk,
  input  logic               rst_n,
  input  uart_cmd_pkg::cmd_t cmd_in,
  input  logic               cmd_vld,
  output logic               cmd_rdy,
  input  logic               bit_tick,
  input  logic               frame_done,
  output logic               timer_start,
  output logic               timer_half,
  output logic               tx_load,
  output logic [7:0]         tx_byte,
  output logic               tx_shift,
  input  logic               rx_start,
  output logic               rx_sample,
  input  logic [7:0]         rx_byte,
  input  logic               parity_ok,
  output logic [7:0]         read_data,
  output logic               read_rdy,
  output logic               read_err
);

  uart_cmd_pkg::state_e state;
  uart_cmd_pkg::state_e state_nxt;
  uart_cmd_pkg::cmd_t   cmd_q;
  logic                 wr_last;
  logic                 gap_end;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= uart_cmd_pkg::IDLE;
      wr_last <= 1'b0;
    end else begin
      state   <= state_nxt;
      wr_last <= frame_done && (state == uart_cmd_pkg::W_DATA_FRAME); // Stop bit just ended.
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_vld && cmd_rdy)
      cmd_q <= cmd_in;
  end

  always_comb begin
    state_nxt = state;
    case (state)
      uart_cmd_pkg::IDLE:
        if (cmd_vld) state_nxt = uart_cmd_pkg::RW_JUDGE;
      uart_cmd_pkg::RW_JUDGE:
        state_nxt = cmd_q.rw ? uart_cmd_pkg::W_ADDR_FRAME : uart_cmd_pkg::R_ADDR_FRAME;
      uart_cmd_pkg::W_ADDR_FRAME:
        if (frame_done) state_nxt = uart_cmd_pkg::W_GAP;
      uart_cmd_pkg::W_GAP:
        if (bit_tick) state_nxt = uart_cmd_pkg::W_DATA_FRAME;
      uart_cmd_pkg::W_DATA_FRAME:
        if (wr_last) state_nxt = uart_cmd_pkg::IDLE;
      uart_cmd_pkg::R_ADDR_FRAME:
        if (frame_done) state_nxt = uart_cmd_pkg::R_WAIT_START;
      uart_cmd_pkg::R_WAIT_START:
        if (rx_start) state_nxt = uart_cmd_pkg::R_DATA_FRAME;
      uart_cmd_pkg::R_DATA_FRAME:
        if (frame_done) state_nxt = uart_cmd_pkg::SEND_READ_DATA;
      uart_cmd_pkg::SEND_READ_DATA:
        state_nxt = uart_cmd_pkg::IDLE;
      default:
        state_nxt = uart_cmd_pkg::IDLE;
    endcase
  end

  // The idle gap between the two write frames is one timer bit.
  assign gap_end = (state == uart_cmd_pkg::W_GAP) && bit_tick;

  assign cmd_rdy     = (state == uart_cmd_pkg::IDLE);
  assign timer_start = (state == uart_cmd_pkg::RW_JUDGE) || gap_end ||
                       ((state == uart_cmd_pkg::W_ADDR_FRAME) && frame_done);
  assign timer_half  = (state == uart_cmd_pkg::R_WAIT_START) && rx_start;

  assign tx_load  = (state == uart_cmd_pkg::RW_JUDGE) || gap_end;
  assign tx_byte  = (state == uart_cmd_pkg::W_GAP) ? cmd_q.data : {cmd_q.rw, cmd_q.addr};
  assign tx_shift = bit_tick && ((state == uart_cmd_pkg::W_ADDR_FRAME) ||
                                 (state == uart_cmd_pkg::W_DATA_FRAME) ||
                                 (state == uart_cmd_pkg::R_ADDR_FRAME));

  // Ticks fall at bit centers here: start, data and parity are sampled, the stop is not.
  assign rx_sample = (state == uart_cmd_pkg::R_DATA_FRAME) && bit_tick && !frame_done;

  always_ff @(posedge clk) begin
    if ((state == uart_cmd_pkg::R_DATA_FRAME) && frame_done)
      read_data <= rx_byte;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      read_err <= 1'b0;
    else if ((state == uart_cmd_pkg::R_DATA_FRAME) && frame_done)
      read_err <= !parity_ok;
  end

  assign read_rdy = (state == uart_cmd_pkg::SEND_READ_DATA);

endmodule

/* design/uart_cmd_master.sv */
`timescale 1ns/10ps

module uart_cmd_master #(
  parameter int BR = 434
) (
  input  logic               clk,
  input  logic               rst_n,
  input  uart_cmd_pkg::cmd_t cmd_in,
  input  logic               cmd_vld,
  output logic               cmd_rdy,
  output logic               tx,
  input  logic               rx,
  output logic [7:0]         read_data,
  output logic               read_rdy,
  output logic               read_err
);

  logic       bit_tick;
  logic       frame_done;
  logic       timer_start;
  logic       timer_half;
  logic       tx_load;
  logic [7:0] tx_byte;
  logic       tx_shift;
  logic       rx_start;
  logic       rx_sample;
  logic [7:0] rx_byte;
  logic       parity_ok;

  uart_ctrl_fsm i_uart_ctrl_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .bit_tick   (bit_tick),
    .frame_done (frame_done),
    .timer_start(timer_start),
    .timer_half (timer_half),
    .tx_load    (tx_load),
    .tx_byte    (tx_byte),
    .tx_shift   (tx_shift),
    .rx_start   (rx_start),
    .rx_sample  (rx_sample),
    .rx_byte    (rx_byte),
    .parity_ok  (parity_ok),
    .read_data  (read_data),
    .read_rdy   (read_rdy),
    .read_err   (read_err)
  );

  uart_bit_timer #(.BR(BR)) i_uart_bit_timer (
    .clk        (clk),
    .rst_n      (rst_n),
    .timer_start(timer_start),
    .timer_half (timer_half),
    .bit_tick   (bit_tick),
    .bit_idx    (),
    .frame_done (frame_done)
  );

  uart_tx_shift i_uart_tx_shift (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_load (tx_load),
    .tx_byte (tx_byte),
    .tx_shift(tx_shift),
    .tx      (tx)
  );

  uart_rx_shift i_uart_rx_shift (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_start (rx_start),
    .rx_sample(rx_sample),
    .rx_byte  (rx_byte),
    .parity_ok(parity_ok)
  );

endmodule

/* bench/uart_cmd_master_props.sv */
`timescale 1ns/10ps

module uart_cmd_master_props (
  input logic               clk,
  input logic               rst_n,
  input uart_cmd_pkg::cmd_t cmd_in,
  input logic               cmd_vld,
  input logic               cmd_rdy,
  input logic               tx,
  input logic               read_rdy
);

  logic wr_busy; // A write is in flight.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      wr_busy <= 1'b0;
    else if (cmd_vld && cmd_rdy)
      wr_busy <= cmd_in.rw;
    else if (cmd_rdy)
      wr_busy <= 1'b0;
  end

  a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
    else $error("tx low while the master is idle");
  a_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else $error("read_rdy held longer than one cycle");
  a_accept: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_vld && cmd_rdy |=> !cmd_rdy)
    else $error("cmd_rdy stayed high after acceptance");
  a_no_read_on_write: assert property (@(posedge clk) disable iff (!rst_n)
    wr_busy |-> !read_rdy)
    else $error("read_rdy pulsed during a write");

endmodule

bind uart_cmd_master uart_cmd_master_props i_uart_cmd_master_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .cmd_in  (cmd_in),
  .cmd_vld (cmd_vld),
  .cmd_rdy (cmd_rdy),
  .tx      (tx),
  .read_rdy(read_rdy)
);

/* bench/uart_cmd_master_tb.sv */
`timescale 1ns/10ps

module uart_cmd_master_tb;

  localparam int BR      = 16;
  localparam int NUM_VEC = 10;
  localparam int LIMIT   = 1000; // Cycles any single wait may take.

  // One line of the golden file.
  typedef struct packed {
    uart_cmd_pkg::cmd_t cmd;
    logic [7:0]         resp;
    logic [3:0]         corrupt;
    logic [7:0]         exp_data;
    logic [3:0]         exp_err;
  } vec_t;

  logic               clk;
  logic               rst_n;
  uart_cmd_pkg::cmd_t cmd_in;
  logic               cmd_vld;
  logic               cmd_rdy;
  logic               tx;
  logic               rx;
  logic [7:0]         read_data;
  logic               read_rdy;
  logic               read_err;

  logic [39:0] raw [0:NUM_VEC-1];
  logic [15:0] lfsr;
  int          cyc = 0;
  int          errors = 0;
  int          timeouts = 0;

  uart_cmd_master #(.BR(BR)) i_uart_cmd_master (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx       (tx),
    .rx       (rx),
    .read_data(read_data),
    .read_rdy (read_rdy),
    .read_err (read_err)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1; // Read only at falling edges.

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timeout: %s", what);
  endtask

  task automatic drive_cmd(input uart_cmd_pkg::cmd_t c);
    @(posedge clk);
    cmd_in  <= c;
    cmd_vld <= 1'b1;
  endtask

  // Called at a falling edge. Returns the cycle count seen just after the accepting edge.
  task automatic wait_accept(output int acc);
    int n;
    n = 0;
    while (!cmd_rdy && n < LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy) report_timeout("cmd_rdy never rose for a pending command");
    @(posedge clk);
    cmd_vld <= 1'b0;
    @(negedge clk);
    acc = cyc;
  endtask

  task automatic wait_rdy(input string what);
    int n;
    n = 0;
    while (!cmd_rdy && n < LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy) report_timeout(what);
  endtask

  // Decodes one frame on tx by sampling each bit at its center.
  task automatic get_frame(output logic [7:0] data, output logic par, output logic stop,
                           output int start_cyc);
    int n;
    n = 0;
    @(negedge clk);
    while (tx !== 1'b0 && n < LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (tx !== 1'b0) report_timeout("no start bit appeared on tx");
    start_cyc = cyc;
    repeat (BR / 2) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      repeat (BR) @(negedge clk);
      data[i] = tx;
    end
    repeat (BR) @(negedge clk);
    par = tx;
    repeat (BR) @(negedge clk);
    stop = tx;
  endtask

  task automatic check_write(input uart_cmd_pkg::cmd_t c, input int acc);
    logic [7:0] d;
    logic       p;
    logic       s;
    int         t1;
    int         t2;
    get_frame(d, p, s, t1);
    check_hex("address start delay", 32'(t1 - acc), 32'd1);
    check_hex("tx address byte", 32'(d), 32'({1'b1, c.addr}));
    check_hex("tx address parity", 32'(p), 32'(^d));
    check_hex("tx address stop", 32'(s), 32'd1);
    get_frame(d, p, s, t2);
    check_hex("frame spacing", 32'(t2 - t1), 32'(12 * BR)); // Eleven bits plus one idle bit.
    check_hex("tx data byte", 32'(d), 32'(c.data));
    check_hex("tx data parity", 32'(p), 32'(^d));
    check_hex("tx data stop", 32'(s), 32'd1);
    wait_rdy("cmd_rdy did not return after a write");
    check_hex("write duration", 32'(cyc - acc), 32'(23 * BR + 2));
  endtask

  task automatic check_read(input vec_t v);
    logic [7:0] d;
    logic       p;
    logic       s;
    logic [9:0] bits;
    int         t1;
    int         gap;
    int         n;
    get_frame(d, p, s, t1);
    check_hex("tx read address byte", 32'(d), 32'({1'b0, v.cmd.addr}));
    check_hex("tx read address parity", 32'(p), 32'(^d));
    check_hex("tx read address stop", 32'(s), 32'd1);
    gap = 0;
    for (int i = 0; i < 5; i++) begin
      lfsr = lfsr_next(lfsr);
      gap  = gap * 2 + int'(lfsr[0]);
    end
    bits = {^v.resp ^ v.corrupt[0], v.resp, 1'b0};
    repeat (BR + gap) @(posedge clk); // Past the stop bit, so the master is listening.
    for (int i = 0; i < 10; i++) begin
      rx <= bits[i];
      repeat (BR) @(posedge clk);
    end
    rx <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!read_rdy && n < LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!read_rdy) report_timeout("read_rdy never pulsed after the response");
    check_hex("read_data", 32'(read_data), 32'(v.exp_data));
    check_hex("read_err", 32'(read_err), 32'(v.exp_err));
    @(negedge clk);
    check_hex("cmd_rdy after read_rdy", 32'(cmd_rdy), 32'd1);
    repeat (BR) @(negedge clk);
  endtask

  initial begin
    vec_t v;
    vec_t w;
    int   acc;
    logic quiet;
    $readmemh("bench/uart_cmd_golden.txt", raw);
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    lfsr    = 16'd17269;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_hex("tx after reset", 32'(tx), 32'd1);
    check_hex("cmd_rdy after reset", 32'(cmd_rdy), 32'd1);
    check_hex("read_rdy after reset", 32'(read_rdy), 32'd0);

    for (int i = 0; i < NUM_VEC; i++) begin
      v = vec_t'(raw[i]);
      drive_cmd(v.cmd);
      @(negedge clk);
      wait_accept(acc);
      if (v.cmd.rw)
        check_write(v.cmd, acc);
      else
        check_read(v);
    end

    // Second write held while the first is still busy.
    v = vec_t'(raw[0]);
    w = vec_t'(raw[1]);
    drive_cmd(v.cmd);
    @(negedge clk);
    wait_accept(acc);
    drive_cmd(w.cmd);
    check_write(v.cmd, acc);
    wait_accept(acc);
    check_write(w.cmd, acc);
    quiet = 1'b1;
    repeat (30 * BR) begin
      @(negedge clk);
      if (!tx) quiet = 1'b0;
    end
    assert (quiet && cmd_rdy) else begin
      errors++;
      $display("the held command ran more than once");
    end

    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

/* bench/uart_cmd_golden.txt */
// Digits 1-4 command word, 5-6 slave response byte, 7 corrupt parity flag,
// 8-9 expected read_data, 10 expected read_err. Response fields are unused for writes.
92A5000000
FF00000000
05003C03C0
3300811811
C05A000000
7E00FF0FF0
0100001001
ABC3000000
6C00960960
8001000000

/* files.f */
design/uart_cmd_pkg.sv
design/uart_bit_timer.sv
design/uart_tx_shift.sv
design/uart_rx_shift.sv
design/uart_ctrl_fsm.sv
design/uart_cmd_master.sv
bench/uart_cmd_master_props.sv
bench/uart_cmd_master_tb.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -sv -f files.f \
		--top-module uart_cmd_master_tb -Mdir obj_dir -o sim

run: compile
	@out="$$(./obj_dir/sim)"; echo "$$out"; \
		echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf obj_dir
